/* source/wallace_config.svh */
`ifndef WALLACE_CONFIG_SVH
`define WALLACE_CONFIG_SVH

// multiplier operand width.
`define WM_OPERAND_WIDTH 32

// product width and the width of every partial-product row.
`define WM_PRODUCT_WIDTH 64

// one half of the final carry-propagate adder.
`define WM_PREFIX_WIDTH 32

// carry-save levels taking 32 rows down to 2.
`define WM_REDUCE_LEVELS 8

`endif

/* source/wallace_pkg.sv */
`include "wallace_config.svh"

package wallace_pkg;

	typedef logic [`WM_OPERAND_WIDTH-1:0] operand_t;

	// one row, already shifted into product position.
	typedef logic [`WM_PRODUCT_WIDTH-1:0] row_t;

	typedef struct packed {
		logic [`WM_PREFIX_WIDTH-1:0] hi; // upper prefix adder result.
		logic [`WM_PREFIX_WIDTH-1:0] lo; // lower prefix adder result.
	} product_halves_t;

	typedef union packed {
		logic [`WM_PRODUCT_WIDTH-1:0] full;
		product_halves_t halves;
	} product_t;

	// rows left after one 3:2 level where leftover rows pass straight through.
	function automatic int next_row_count(int rows_in);
		return 2 * (rows_in / 3) + rows_in % 3;
	endfunction

endpackage

/* source/prefix_adder.sv */
`timescale 1ns/1ps

`include "wallace_config.svh"

module prefix_adder #(
	parameter int WIDTH = `WM_PREFIX_WIDTH
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             carry_in,
	output logic [WIDTH-1:0] sum,
	output logic             carry_out
);

	localparam int LEVELS = $clog2(WIDTH);

	always_comb begin
		logic [WIDTH-1:0] half_sum;
		logic [WIDTH-1:0] gen;
		logic [WIDTH-1:0] prop;

		half_sum = a ^ b;
		gen = a & b;
		prop = half_sum;
		gen[0] = gen[0] | (prop[0] & carry_in); // carry in folded into bit 0.

		// kogge-stone tree whose span doubles every level.
		for (int lvl = 0; lvl < LEVELS; lvl++) begin
			gen = gen | (prop & (gen << (1 << lvl)));
			prop = prop & ((prop << (1 << lvl)) | ~({WIDTH{1'b1}} << (1 << lvl)));
		end

		// gen[i] now holds the carry out of bit i.
		sum = half_sum ^ {gen[WIDTH-2:0], carry_in};
		carry_out = gen[WIDTH-1];
	end

endmodule

/* source/partial_product_gen.sv */
`timescale 1ns/1ps

`include "wallace_config.svh"

module partial_product_gen import wallace_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  operand_t x,
	input  operand_t y,
	output logic     out_valid,
	output row_t     rows [`WM_OPERAND_WIDTH]
);

	// row i is x gated by y[i] and moved up i columns.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			for (int i = 0; i < `WM_OPERAND_WIDTH; i++) begin
				rows[i] <= '0;
			end
		end else begin
			out_valid <= in_valid;
			for (int i = 0; i < `WM_OPERAND_WIDTH; i++) begin
				rows[i] <= row_t'(x & {`WM_OPERAND_WIDTH{y[i]}}) << i;
			end
		end
	end

	// nothing leaves the array on the first edge after reset goes away.
	first_cycle_idle: assert property (
		@(posedge clk) $rose(arst_n) |-> !out_valid
	);

endmodule

/* source/csa_reduce_level.sv */
`timescale 1ns/1ps

module csa_reduce_level import wallace_pkg::*; #(
	parameter int ROWS_IN = 32
) (
	input  logic clk,
	input  logic arst_n,
	input  logic in_valid,
	input  row_t rows_in [ROWS_IN],
	output logic out_valid,
	output row_t rows_out [next_row_count(ROWS_IN)]
);

	localparam int GROUPS   = ROWS_IN / 3;
	localparam int ROWS_OUT = next_row_count(ROWS_IN);

	row_t next_rows [ROWS_OUT];
	row_t in_total;
	row_t out_total;

	always_comb begin
		for (int g = 0; g < GROUPS; g++) begin
			// full adder per column.
			next_rows[2*g] = rows_in[3*g] ^ rows_in[3*g+1] ^ rows_in[3*g+2];
			next_rows[2*g+1] = ((rows_in[3*g] & rows_in[3*g+1]) |
				(rows_in[3*g] & rows_in[3*g+2]) |
				(rows_in[3*g+1] & rows_in[3*g+2])) << 1; // carry goes one column up.
		end
		for (int r = 3 * GROUPS; r < ROWS_IN; r++) begin
			next_rows[r - GROUPS] = rows_in[r]; // leftover rows.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			for (int r = 0; r < ROWS_OUT; r++) begin
				rows_out[r] <= '0;
			end
		end else begin
			out_valid <= in_valid;
			for (int r = 0; r < ROWS_OUT; r++) begin
				rows_out[r] <= next_rows[r];
			end
		end
	end

	// column sums on both sides of the register.
	always_comb begin
		in_total = '0;
		for (int r = 0; r < ROWS_IN; r++) begin
			in_total = in_total + rows_in[r];
		end
	end

	always_comb begin
		out_total = '0;
		for (int r = 0; r < ROWS_OUT; r++) begin
			out_total = out_total + rows_out[r];
		end
	end

	// compression must not change the value the rows stand for.
	sum_preserved: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid |=> out_total == $past(in_total)
	);

endmodule

/* source/final_adder.sv */
`timescale 1ns/1ps

`include "wallace_config.svh"

module final_adder import wallace_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  row_t     sum_row,
	input  row_t     carry_row,
	output logic     out_valid,
	output product_t product
);

	product_t product_next;
	logic     mid_carry;
	logic     top_carry;

	prefix_adder #(
		.WIDTH(`WM_PREFIX_WIDTH)
	) prefix_adder_lo (
		.a        (sum_row[`WM_PREFIX_WIDTH-1:0]),
		.b        (carry_row[`WM_PREFIX_WIDTH-1:0]),
		.carry_in (1'b0),
		.sum      (product_next.halves.lo),
		.carry_out(mid_carry)
	);

	// upper half waits on the lower carry.
	prefix_adder #(
		.WIDTH(`WM_PREFIX_WIDTH)
	) prefix_adder_hi (
		.a        (sum_row[`WM_PRODUCT_WIDTH-1:`WM_PREFIX_WIDTH]),
		.b        (carry_row[`WM_PRODUCT_WIDTH-1:`WM_PREFIX_WIDTH]),
		.carry_in (mid_carry),
		.sum      (product_next.halves.hi),
		.carry_out(top_carry)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			product <= '0;
		end else begin
			out_valid <= in_valid;
			product <= product_next;
		end
	end

	// a 32x32 product fits in 64 bits if the tree above kept its sum.
	no_product_overflow: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid |-> !top_carry
	);

endmodule

/* source/wallace_mult_top.sv */
`timescale 1ns/1ps

`include "wallace_config.svh"

module wallace_mult_top import wallace_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  operand_t x,
	input  operand_t y,
	output logic     out_valid,
	output product_t product
);

	// rows entering a given reduction level.
	function automatic int rows_at_level(int lvl);
		int n;
		n = `WM_OPERAND_WIDTH;
		for (int k = 0; k < lvl; k++) begin
			n = next_row_count(n);
		end
		return n;
	endfunction

	logic pp_valid;
	row_t pp_rows [`WM_OPERAND_WIDTH];

	partial_product_gen partial_product_gen_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.x        (x),
		.y        (y),
		.out_valid(pp_valid),
		.rows     (pp_rows)
	);

	// 32, 22, 15, 10, 7, 5, 4, 3 rows in, 2 out of the last level.
	for (genvar i = 0; i < `WM_REDUCE_LEVELS; i++) begin : level
		localparam int N_IN  = rows_at_level(i);
		localparam int N_OUT = next_row_count(N_IN);

		logic valid_in;
		row_t rows_in [N_IN];
		logic valid_out;
		row_t rows_out [N_OUT];

		if (i == 0) begin : g_first
			assign valid_in = pp_valid;
			assign rows_in = pp_rows;
		end else begin : g_chain
			assign valid_in = level[i-1].valid_out;
			assign rows_in = level[i-1].rows_out;
		end

		csa_reduce_level #(
			.ROWS_IN(N_IN)
		) csa_reduce_level_inst (
			.clk      (clk),
			.arst_n   (arst_n),
			.in_valid (valid_in),
			.rows_in  (rows_in),
			.out_valid(valid_out),
			.rows_out (rows_out)
		);
	end

	final_adder final_adder_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (level[`WM_REDUCE_LEVELS-1].valid_out),
		.sum_row  (level[`WM_REDUCE_LEVELS-1].rows_out[0]),
		.carry_row(level[`WM_REDUCE_LEVELS-1].rows_out[1]),
		.out_valid(out_valid),
		.product  (product)
	);

endmodule

/* bench/wallace_mult_tb.sv */
`timescale 1ns/1ps

`include "wallace_config.svh"

module wallace_mult_tb import wallace_pkg::*; ();

	localparam int LATENCY = 10;
	localparam int TIMEOUT_CYCLES = 20;

	logic     clk;
	logic     arst_n;
	logic     in_valid;
	operand_t x;
	operand_t y;
	logic     out_valid;
	product_t product;

	int          cycle = 0;
	int          mismatch_count = 0;
	int          failure_count = 0;
	bit          driving = 0;
	logic [31:0] lfsr_state = 32'h14f3;
	product_t    exp_q[$];
	int          due_q[$];

	wallace_mult_top wallace_mult_top_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.x        (x),
		.y        (y),
		.out_valid(out_valid),
		.product  (product)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// taps 32, 22, 2, 1.
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic operand_t random_operand();
		operand_t w;
		w = '0;
		for (int i = 0; i < `WM_OPERAND_WIDTH; i++) begin
			w = {w[`WM_OPERAND_WIDTH-2:0], next_random_bit()};
		end
		return w;
	endfunction

	function automatic product_t expected_product(operand_t a, operand_t b);
		product_t p;
		p.full = row_t'(a) * row_t'(b);
		return p;
	endfunction

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s out_valid at cycle %0d: expected %b, actual %b",
				name, cycle, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_product(input string name, input product_t exp, input product_t act,
			input bit per_half);
		if (per_half) begin
			if (act.halves.hi !== exp.halves.hi) begin
				$display("MISMATCH %s hi half: expected %h, actual %h",
					name, exp.halves.hi, act.halves.hi);
				mismatch_count++;
			end
			if (act.halves.lo !== exp.halves.lo) begin
				$display("MISMATCH %s lo half: expected %h, actual %h",
					name, exp.halves.lo, act.halves.lo);
				mismatch_count++;
			end
		end else if (act.full !== exp.full) begin
			$display("MISMATCH %s product: expected %h, actual %h", name, exp.full, act.full);
			mismatch_count++;
		end
	endtask

	task automatic issue_pair(input operand_t a, input operand_t b);
		@(posedge clk);
		in_valid <= 1'b1;
		x <= a;
		y <= b;
		exp_q.push_back(expected_product(a, b));
		due_q.push_back(cycle + 1 + LATENCY); // cycle still holds the count before this edge.
	endtask

	task automatic drop_valid();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// runs beside the driver and looks once per falling edge.
	task automatic watch_outputs(input string name, input bit per_half);
		int       idle;
		logic     exp_valid;
		product_t exp_prod;
		idle = 0;
		while (driving || exp_q.size() != 0) begin
			@(negedge clk);
			exp_valid = exp_q.size() != 0 && due_q[0] == cycle;
			check_valid(name, exp_valid, out_valid);
			if (out_valid) begin
				idle = 0;
				if (exp_q.size() != 0 && due_q[0] <= cycle) begin
					exp_prod = exp_q.pop_front();
					void'(due_q.pop_front());
					check_product(name, exp_prod, product, per_half);
				end
			end else if (exp_q.size() != 0) begin
				idle++; // a product is still owed.
			end else begin
				idle = 0;
			end
			if (idle > TIMEOUT_CYCLES) begin
				$display("%s: no product arrived within %0d cycles", name, TIMEOUT_CYCLES);
				failure_count++;
				break;
			end
		end
	endtask

	task automatic single_product(input string name, input operand_t a, input operand_t b,
			input bit per_half);
		driving = 1'b1;
		fork
			begin
				issue_pair(a, b);
				drop_valid();
				driving = 1'b0;
			end
			watch_outputs(name, per_half);
		join
		exp_q.delete();
		due_q.delete();
	endtask

	task automatic reset_quiet();
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_valid("reset_state", 1'b0, out_valid);
		end
		@(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < LATENCY; i++) begin
			@(negedge clk);
			check_valid("reset_state", 1'b0, out_valid); // nothing issued yet.
		end
	endtask

	task automatic corner_products();
		single_product("corner_zero", 32'h0000_0000, 32'h1234_5678, 1'b0);
		single_product("corner_one", 32'h0000_0001, 32'hdead_beef, 1'b0);
		single_product("corner_all_ones", 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		single_product("corner_top_bit", 32'h8000_0000, 32'h8000_0000, 1'b0);
	endtask

	task automatic full_throughput();
		driving = 1'b1;
		fork
			begin
				for (int i = 0; i < 64; i++) begin
					issue_pair(random_operand(), random_operand());
				end
				drop_valid();
				driving = 1'b0;
			end
			watch_outputs("full_throughput", 1'b0);
		join
		exp_q.delete();
		due_q.delete();
	endtask

	task automatic bubble_pattern();
		driving = 1'b1;
		fork
			begin
				for (int i = 0; i < 40; i++) begin
					if (next_random_bit()) begin
						issue_pair(random_operand(), random_operand());
					end else begin
						drop_valid();
					end
				end
				drop_valid();
				driving = 1'b0;
			end
			watch_outputs("bubbles", 1'b0);
		join
		exp_q.delete();
		due_q.delete();
	endtask

	// 0x5555_5557 times 3 leaves a carry chain that only the final adder carries past bit 31.
	task automatic half_products();
		single_product("halves_ones_x2", 32'hffff_ffff, 32'h0000_0002, 1'b1);
		single_product("halves_ffff", 32'h0000_ffff, 32'h0001_0001, 1'b1);
		single_product("halves_long_chain", 32'h5555_5557, 32'h0000_0003, 1'b1);
		single_product("halves_mixed", 32'h8000_0001, 32'hffff_ffff, 1'b1);
		single_product("halves_all_ones", 32'hffff_ffff, 32'hffff_ffff, 1'b1);
	endtask

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		x = '0;
		y = '0;
		reset_quiet();
		corner_products();
		full_throughput();
		bubble_pattern();
		half_products();
		$display("mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* src.f */
+incdir+source
source/wallace_pkg.sv
source/prefix_adder.sv
source/partial_product_gen.sv
source/csa_reduce_level.sv
source/final_adder.sv
source/wallace_mult_top.sv
bench/wallace_mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module wallace_mult_tb \
	-Mdir obj_dir -o wallace_mult_sim \
	&& ./obj_dir/wallace_mult_sim | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }

test -f sim.log || { echo "no simulation log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "simulation reported failures"; exit 1; }
exit 0
